//--- sim.f
verilog/bus_ctrl_pkg.sv
verilog/menu_fsm.sv
verilog/data_bank.sv
verilog/config_sequencer.sv
verilog/com_launcher.sv
verilog/bus_ctrl_top.sv
dv/bus_ctrl_properties.sv
dv/tb_bus_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_bus_ctrl -f sim.f -o tb_bus_ctrl

output=$(./obj_dir/tb_bus_ctrl)
echo "$output"

if grep -q "^Verification passed$" <<< "$output"; then
    exit 0
fi
exit 1

//--- dv/tb_bus_ctrl.sv
`timescale 1ns/1ps

module tb_bus_ctrl;

    localparam int CLK_PERIOD      = 4;
    localparam int COM_START_DELAY = 3;
    localparam int TEST_CYCLES     = 250;  // rough length of all tests together

    logic        clk;
    logic        rstN;
    logic        step;
    logic        next_word;
    logic [17:0] sw;
    logic [1:0]  done_com;
    bus_ctrl_pkg::master_cmd_t cmd [bus_ctrl_pkg::MASTER_COUNT];
    logic [3:0]  status;

    int errors;
    int tests;
    int reset_cycles;
    int cfg_pulses;  // config start pulses seen so far
    int word_timer;  // cycles since the last config start
    logic [1:0] done_seen;

    bus_ctrl_pkg::data_t     bank_model [2][16];
    int                      exp_count [2];
    logic [1:0]              exp_burst;
    bus_ctrl_pkg::slave_id_t exp_id [2];
    bus_ctrl_pkg::addr_t     exp_first [2];
    bus_ctrl_pkg::addr_t     exp_last [2];

    logic                        cfg_pulse;
    logic                        cur_m;
    bus_ctrl_pkg::addr_t         cur_addr;
    bus_ctrl_pkg::data_t         cur_data;
    bus_ctrl_pkg::master_setup_t cur_setup;
    int                          exp_gap;

    bus_ctrl_top #(
        .BANK_DEPTH(16),
        .COM_START_DELAY(COM_START_DELAY),
        .FIRST_START_MASTER(1)
    ) bus_ctrl_top_i (
        .clk, .rstN, .step, .next_word, .sw, .done_com, .cmd, .status
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign cfg_pulse = (status == 4'b0000) && (cmd[0].start || cmd[1].start);
    assign cur_m     = cfg_pulses[1];  // two pulses per master
    assign cur_addr  = cur_m ? cmd[1].address : cmd[0].address;
    assign cur_data  = cur_m ? cmd[1].data : cmd[0].data;
    assign cur_setup = cur_m ? cmd[1].setup : cmd[0].setup;
    assign exp_gap   = (exp_count[cur_m] >= 2) ? 2 * exp_count[cur_m] : 2;

    always_ff @(posedge clk) begin
        reset_cycles <= rstN ? 0 : reset_cycles + 1;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg_pulses <= 0;
            word_timer <= 0;
            done_seen  <= '0;
        end else begin
            word_timer <= cfg_pulse ? 1 : word_timer + 1;
            if (cfg_pulse) cfg_pulses <= cfg_pulses + 1;
            if (status == 4'b1000) done_seen <= done_seen | done_com;
        end
    end

    reset_values: assert property (@(posedge clk) (!rstN && reset_cycles >= 1) |->
        status == 4'b0001 && !cmd[0].start && !cmd[1].start && !cmd[0].eoc && !cmd[1].eoc)
        else begin errors++; $display("MISMATCH at %0t: outputs wrong during reset", $time); end

    shortcut_eoc: assert property (@(posedge clk) disable iff (!rstN)
        (step && status == 4'b0001 && sw[3:0] == 4'h0) |=>
        (cmd[0].eoc && cmd[1].eoc && status == 4'b0100) ##1 (!cmd[0].eoc && !cmd[1].eoc))
        else begin errors++; $display("MISMATCH at %0t: no-slave eoc pulse wrong", $time); end

    done_no_start: assert property (@(posedge clk) disable iff (!rstN)
        status == 4'b0100 |-> !cmd[0].start && !cmd[1].start)
        else begin errors++; $display("MISMATCH at %0t: start after completion", $time); end

    cfg_order: assert property (@(posedge clk) disable iff (!rstN)
        cfg_pulse |-> cfg_pulses < 4 &&
        (cur_m ? (cmd[1].start && !cmd[0].start) : (cmd[0].start && !cmd[1].start)))
        else begin errors++; $display("MISMATCH at %0t: config start order", $time); end

    cfg_address: assert property (@(posedge clk) disable iff (!rstN)
        cfg_pulse |-> cur_addr == (cfg_pulses[0] ? exp_last[cur_m] : exp_first[cur_m]))
        else begin errors++; $display("MISMATCH at %0t: config address %0d", $time, cur_addr); end

    // both masters were set to write and to take words by hand
    cfg_setup: assert property (@(posedge clk) disable iff (!rstN)
        cfg_pulse |-> cur_setup.burst == exp_burst[cur_m] &&
        cur_setup.slave_id == exp_id[cur_m] &&
        cur_setup.rd_wr == 1'b1 && cur_setup.in_ex == 1'b1 &&
        cur_setup.first_addr == exp_first[cur_m] && cur_setup.last_addr == exp_last[cur_m])
        else begin errors++; $display("MISMATCH at %0t: setup fields", $time); end

    cfg_first_word: assert property (@(posedge clk) disable iff (!rstN)
        (cfg_pulse && !cfg_pulses[0]) |-> cur_data == bank_model[cur_m][0])
        else begin errors++; $display("MISMATCH at %0t: word 0 is %h", $time, cur_data); end

    cfg_words: assert property (@(posedge clk) disable iff (!rstN)
        (status == 4'b0000 && !cfg_pulse && cfg_pulses[0] && word_timer >= 2 &&
         word_timer % 2 == 0 && word_timer / 2 < exp_count[cur_m]) |->
        cur_data == bank_model[cur_m][word_timer / 2])
        else begin errors++; $display("MISMATCH at %0t: bank word %h", $time, cur_data); end

    cfg_last_time: assert property (@(posedge clk) disable iff (!rstN)
        (cfg_pulse && cfg_pulses[0]) |-> word_timer == exp_gap)
        else begin errors++; $display("MISMATCH at %0t: second start after %0d", $time,
                                      word_timer); end

    cfg_complete: assert property (@(posedge clk) disable iff (!rstN)
        $rose(status[1]) |-> cfg_pulses == 4)
        else begin errors++; $display("MISMATCH at %0t: %0d config starts", $time,
                                      cfg_pulses); end

    launch_first: assert property (@(posedge clk) disable iff (!rstN)
        (step && status == 4'b0010) |=> status == 4'b1000 && cmd[1].start && !cmd[0].start)
        else begin errors++; $display("MISMATCH at %0t: master 1 start or busy light", $time); end

    launch_second: assert property (@(posedge clk) disable iff (!rstN)
        (step && status == 4'b0010) |-> ##(COM_START_DELAY + 2) (cmd[0].start && !cmd[1].start))
        else begin errors++; $display("MISMATCH at %0t: master 0 start late", $time); end

    com_hold: assert property (@(posedge clk) disable iff (!rstN)
        (status == 4'b1000 && !(&(done_seen | done_com))) |=> status == 4'b1000)
        else begin errors++; $display("MISMATCH at %0t: left communicating early", $time); end

    com_finish: assert property (@(posedge clk) disable iff (!rstN)
        (status == 4'b1000 && &(done_seen | done_com)) |=> status == 4'b0100)
        else begin errors++; $display("MISMATCH at %0t: no move to done", $time); end

    readback_addr: assert property (@(posedge clk) disable iff (!rstN)
        status == 4'b0100 |-> cmd[0].address == sw[11:0] && cmd[1].address == sw[11:0])
        else begin errors++; $display("MISMATCH at %0t: readback address", $time); end

    function automatic bus_ctrl_pkg::addr_t expected_end(input int first, input int len,
                                                         input int depth);
        if (first + len > depth - 1) begin
            return bus_ctrl_pkg::addr_t'(depth - 1);
        end
        return bus_ctrl_pkg::addr_t'(first + len);
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    task automatic pulse_step(input logic [17:0] value);
        sw   = value;
        step = 1'b1;
        tick();
        step = 1'b0;
    endtask

    task automatic write_words(input int m, input int n);
        bus_ctrl_pkg::data_t w;
        for (int k = 0; k < n; k++) begin
            w                = bus_ctrl_pkg::data_t'($urandom);
            bank_model[m][k] = w;
            sw               = {2'b00, w};
            next_word        = 1'b1;
            tick();
            next_word = 1'b0;
            tick();
        end
        exp_count[m] = n;
        exp_burst[m] = 1'b1;
    endtask

    task automatic pulse_done(input int m);
        done_com[m] = 1'b1;
        tick();
        done_com[m] = 1'b0;
    endtask

    task automatic wait_status(input logic [3:0] value, input int max_cycles);
        int n;
        n = 0;
        while (status !== value && n < max_cycles) begin
            tick();
            n++;
        end
        if (status !== value) begin
            errors++;
            $display("timeout at %0t: status never reached %b", $time, value);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    initial begin
        #(20 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int first;
        int len;
        int order;
        void'($urandom(37711));
        errors    = 0;
        tests     = 0;
        rstN      = 1'b0;
        step      = 1'b0;
        next_word = 1'b0;
        sw        = '0;
        done_com  = '0;
        exp_burst = '0;
        exp_count = '{0, 0};
        exp_id    = '{2'd3, 2'd1};  // slave 3 holds only 2048 words
        apply_reset();
        repeat (3) tick();
        report_test("status after reset");

        pulse_step(18'h0);  // no slave for either master
        wait_status(4'b0100, 10);
        repeat (3) tick();
        report_test("no-slave shortcut");

        apply_reset();
        pulse_step(18'h7);  // master 0 on slave 3, master 1 on slave 1
        pulse_step(18'h3);
        pulse_step(18'h3);  // both masters take words by hand
        write_words(0, 3);
        pulse_step(18'h0);
        write_words(1, 2);
        pulse_step(18'h0);
        first        = 1500 + $urandom % 500;
        exp_first[0] = bus_ctrl_pkg::addr_t'(first);
        pulse_step(18'(first));
        first        = $urandom % 2048;
        exp_first[1] = bus_ctrl_pkg::addr_t'(first);
        pulse_step(18'(first));
        len         = 600 + $urandom % 400;  // runs past the end of slave 3
        exp_last[0] = expected_end(exp_first[0], len, 2048);
        pulse_step(18'(len));
        len         = $urandom % 2048;
        exp_last[1] = expected_end(exp_first[1], len, 4096);
        pulse_step(18'(len));
        wait_status(4'b0010, 100);
        report_test("configuration addresses");
        report_test("data bank words");

        pulse_step(18'h0);
        repeat (COM_START_DELAY + 4) tick();
        report_test("staggered launch");

        order = $urandom % 2;
        pulse_done(order);
        repeat ($urandom % 5 + 1) tick();
        pulse_done(1 - order);
        wait_status(4'b0100, 10);
        repeat (4) begin
            sw = 18'($urandom);
            tick();
        end
        report_test("completion");

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dv/bus_ctrl_properties.sv
`timescale 1ns/1ps

module bus_ctrl_properties (
    input logic                      clk,
    input logic                      rstN,
    input bus_ctrl_pkg::master_cmd_t cmd [bus_ctrl_pkg::MASTER_COUNT],
    input logic [3:0]                status
);

    status_onehot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(status))
        else $error("status lights show more than one phase");

    for (genvar i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) begin : g_master
        start_single: assert property (@(posedge clk) disable iff (!rstN)
            cmd[i].start |=> !cmd[i].start)
            else $error("start of master %0d held for two cycles", i);

        eoc_single: assert property (@(posedge clk) disable iff (!rstN)
            cmd[i].eoc |=> !cmd[i].eoc)
            else $error("eoc of master %0d held for two cycles", i);

        start_eoc_apart: assert property (@(posedge clk) disable iff (!rstN)
            !(cmd[i].start && cmd[i].eoc))
            else $error("start and eoc of master %0d high together", i);
    end

endmodule

bind bus_ctrl_top bus_ctrl_properties bus_ctrl_properties_i (
    .clk(clk), .rstN(rstN), .cmd(cmd), .status(status)
);

//--- verilog/bus_ctrl_top.sv
`timescale 1ns/1ps

module bus_ctrl_top #(
    parameter int BANK_DEPTH         = 16,
    parameter int COM_START_DELAY    = 0,
    parameter int FIRST_START_MASTER = 0
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  logic                                   step,
    input  logic                                   next_word,
    input  logic [17:0]                            sw,
    input  logic [bus_ctrl_pkg::MASTER_COUNT-1:0]  done_com,
    output bus_ctrl_pkg::master_cmd_t              cmd [bus_ctrl_pkg::MASTER_COUNT],
    output logic [3:0]                             status
);

    bus_ctrl_pkg::main_state_t             state;
    bus_ctrl_pkg::master_setup_t           setup [bus_ctrl_pkg::MASTER_COUNT];
    logic [bus_ctrl_pkg::MASTER_COUNT-1:0] eoc;
    logic [bus_ctrl_pkg::MASTER_COUNT-1:0] seq_start;
    logic [bus_ctrl_pkg::MASTER_COUNT-1:0] launch_start;
    logic                                  config_finished;
    logic [$clog2(BANK_DEPTH)-1:0]         rd_addr [bus_ctrl_pkg::MASTER_COUNT];
    bus_ctrl_pkg::data_t                   rd_data [bus_ctrl_pkg::MASTER_COUNT];
    logic [$clog2(BANK_DEPTH+1)-1:0]       word_count [bus_ctrl_pkg::MASTER_COUNT];
    bus_ctrl_pkg::addr_t                   seq_address [bus_ctrl_pkg::MASTER_COUNT];
    bus_ctrl_pkg::data_t                   seq_data [bus_ctrl_pkg::MASTER_COUNT];

    menu_fsm menu_fsm_i (
        .clk, .rstN, .step, .next_word, .sw, .config_finished, .done_com,
        .state, .setup, .eoc, .status
    );

    data_bank #(.BANK_DEPTH(BANK_DEPTH)) data_bank_i (
        .clk, .rstN, .state, .step, .next_word,
        .sw_data(sw[bus_ctrl_pkg::DATA_WIDTH-1:0]),
        .rd_addr, .rd_data, .word_count
    );

    config_sequencer #(.BANK_DEPTH(BANK_DEPTH)) config_sequencer_i (
        .clk, .rstN, .state, .setup, .word_count, .rd_data, .rd_addr,
        .start(seq_start), .address(seq_address), .data(seq_data), .config_finished
    );

    com_launcher #(
        .COM_START_DELAY(COM_START_DELAY),
        .FIRST_START_MASTER(FIRST_START_MASTER)
    ) com_launcher_i (
        .clk, .rstN, .state, .step, .start(launch_start)
    );

    // after the run the switches pick the address to read back
    always_comb begin
        for (int i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) begin
            cmd[i].start   = seq_start[i] | launch_start[i];
            cmd[i].eoc     = eoc[i];
            cmd[i].setup   = setup[i];
            cmd[i].address = (state == bus_ctrl_pkg::communication_done) ?
                             sw[bus_ctrl_pkg::ADDR_WIDTH-1:0] : seq_address[i];
            cmd[i].data    = seq_data[i];
        end
    end

endmodule

//--- verilog/com_launcher.sv
`timescale 1ns/1ps

module com_launcher #(
    parameter int COM_START_DELAY    = 0,
    parameter int FIRST_START_MASTER = 0,
    localparam int CNT_W = (COM_START_DELAY > 0) ? $clog2(COM_START_DELAY + 1) : 1
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  bus_ctrl_pkg::main_state_t              state,
    input  logic                                   step,
    output logic [bus_ctrl_pkg::MASTER_COUNT-1:0]  start
);

    logic [CNT_W-1:0] delay_cnt;
    logic             both_started;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            start        <= '0;
            delay_cnt    <= '0;
            both_started <= 1'b0;
        end else begin
            start <= '0;  // pulses last one cycle
            if (state == bus_ctrl_pkg::communication_ready && step) begin
                if (COM_START_DELAY == 0) begin
                    start        <= '1;
                    both_started <= 1'b1;
                end else begin
                    start[FIRST_START_MASTER] <= 1'b1;
                end
            end else if (state == bus_ctrl_pkg::communicating && !both_started) begin
                delay_cnt <= delay_cnt + 1'b1;
                if (delay_cnt == CNT_W'(COM_START_DELAY)) begin
                    start[1 - FIRST_START_MASTER] <= 1'b1;  // the other master
                    both_started                  <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/config_sequencer.sv
`timescale 1ns/1ps

module config_sequencer #(
    parameter int BANK_DEPTH = 16,
    localparam int AW = $clog2(BANK_DEPTH),
    localparam int CW = $clog2(BANK_DEPTH + 1)
) (
    input  logic                                   clk,
    input  logic                                   rstN,
    input  bus_ctrl_pkg::main_state_t              state,
    input  bus_ctrl_pkg::master_setup_t            setup [bus_ctrl_pkg::MASTER_COUNT],
    input  logic [CW-1:0]                          word_count [bus_ctrl_pkg::MASTER_COUNT],
    input  bus_ctrl_pkg::data_t                    rd_data [bus_ctrl_pkg::MASTER_COUNT],
    output logic [AW-1:0]                          rd_addr [bus_ctrl_pkg::MASTER_COUNT],
    output logic [bus_ctrl_pkg::MASTER_COUNT-1:0]  start,
    output bus_ctrl_pkg::addr_t                    address [bus_ctrl_pkg::MASTER_COUNT],
    output bus_ctrl_pkg::data_t                    data [bus_ctrl_pkg::MASTER_COUNT],
    output logic                                   config_finished
);

    bus_ctrl_pkg::config_state_t cfg_state;
    logic [$clog2(bus_ctrl_pkg::MASTER_COUNT)-1:0] cur;  // master being configured
    logic          phase;  // second cycle of a substate
    logic [AW-1:0] widx [bus_ctrl_pkg::MASTER_COUNT];
    logic          in_config;
    logic          go_middle;
    logic          pulse_slot;

    assign in_config = (state == bus_ctrl_pkg::config_masters);
    // more than one word written by hand for this master
    assign go_middle = setup[cur].in_ex && (word_count[cur] >= CW'(2));
    assign config_finished = in_config && (cfg_state == bus_ctrl_pkg::config_done);
    assign pulse_slot = in_config && !phase &&
                        (cfg_state == bus_ctrl_pkg::config_start ||
                         cfg_state == bus_ctrl_pkg::config_last);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg_state <= bus_ctrl_pkg::config_start;
            cur       <= '0;
            phase     <= 1'b0;
            widx      <= '{default: '0};
        end else if (!in_config) begin
            cfg_state <= bus_ctrl_pkg::config_start;
            cur       <= '0;
            phase     <= 1'b0;
            widx      <= '{default: '0};
        end else if (cfg_state != bus_ctrl_pkg::config_done) begin
            phase <= ~phase;
            if (phase) begin
                case (cfg_state)
                    bus_ctrl_pkg::config_start: begin
                        if (go_middle) begin
                            cfg_state <= bus_ctrl_pkg::config_middle;
                            widx[cur] <= AW'(1);
                        end else begin
                            cfg_state <= bus_ctrl_pkg::config_last;
                        end
                    end
                    bus_ctrl_pkg::config_middle: begin
                        if (CW'(widx[cur]) + CW'(1) == word_count[cur]) begin
                            cfg_state <= bus_ctrl_pkg::config_last;  // last word shown
                        end else begin
                            widx[cur] <= widx[cur] + 1'b1;
                        end
                    end
                    bus_ctrl_pkg::config_last: begin
                        if (int'(cur) == bus_ctrl_pkg::MASTER_COUNT - 1) begin
                            cfg_state <= bus_ctrl_pkg::config_done;
                        end else begin
                            cur       <= cur + 1'b1;
                            cfg_state <= bus_ctrl_pkg::config_start;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // masters already past config_start see their last address
    always_comb begin
        for (int i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) begin
            start[i]   = pulse_slot && (int'(cur) == i);
            rd_addr[i] = widx[i];
            data[i]    = rd_data[i];
            if (i < int'(cur) ||
                (i == int'(cur) && (cfg_state == bus_ctrl_pkg::config_last ||
                                    cfg_state == bus_ctrl_pkg::config_done))) begin
                address[i] = setup[i].last_addr;
            end else begin
                address[i] = setup[i].first_addr;
            end
        end
    end

endmodule

//--- verilog/data_bank.sv
`timescale 1ns/1ps

module data_bank #(
    parameter int BANK_DEPTH = 16,
    localparam int AW = $clog2(BANK_DEPTH),
    localparam int CW = $clog2(BANK_DEPTH + 1)
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  bus_ctrl_pkg::main_state_t  state,
    input  logic                       step,
    input  logic                       next_word,
    input  bus_ctrl_pkg::data_t        sw_data,
    input  logic [AW-1:0]              rd_addr [bus_ctrl_pkg::MASTER_COUNT],
    output bus_ctrl_pkg::data_t        rd_data [bus_ctrl_pkg::MASTER_COUNT],
    output logic [CW-1:0]              word_count [bus_ctrl_pkg::MASTER_COUNT]
);

    bus_ctrl_pkg::data_t mem [bus_ctrl_pkg::MASTER_COUNT][BANK_DEPTH];
    logic [AW-1:0] wr_addr;
    logic          wr_en;
    logic          wr_master;  // bank chosen by the write state

    assign wr_en = state inside {bus_ctrl_pkg::external_write_m1,
                                 bus_ctrl_pkg::external_write_m1_2,
                                 bus_ctrl_pkg::external_write_m2};
    assign wr_master = (state == bus_ctrl_pkg::external_write_m2);

    // current word follows the switches until next_word moves on
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_master][wr_addr] <= sw_data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wr_addr    <= '0;
            word_count <= '{default: '0};
        end else if (wr_en) begin
            if (step) begin
                wr_addr <= '0;  // next master starts at word 0
            end else if (next_word && word_count[wr_master] < CW'(BANK_DEPTH - 1)) begin
                wr_addr                <= wr_addr + 1'b1;
                word_count[wr_master] <= word_count[wr_master] + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) begin
            rd_data[i] = mem[i][rd_addr[i]];
        end
    end

endmodule

//--- verilog/menu_fsm.sv
`timescale 1ns/1ps

module menu_fsm (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    step,
    input  logic                                    next_word,
    input  logic [17:0]                             sw,
    input  logic                                    config_finished,
    input  logic [bus_ctrl_pkg::MASTER_COUNT-1:0]   done_com,
    output bus_ctrl_pkg::main_state_t               state,
    output bus_ctrl_pkg::master_setup_t             setup [bus_ctrl_pkg::MASTER_COUNT],
    output logic [bus_ctrl_pkg::MASTER_COUNT-1:0]   eoc,
    output logic [3:0]                              status
);

    bus_ctrl_pkg::main_state_t next_state;
    logic [bus_ctrl_pkg::MASTER_COUNT-1:0] done_seen;
    logic [bus_ctrl_pkg::MASTER_COUNT-1:0] done_all;  // finished or never took part

    // last address of a run, held inside the chosen slave
    function automatic bus_ctrl_pkg::addr_t clamp_end(input bus_ctrl_pkg::addr_t first,
                                                      input bus_ctrl_pkg::addr_t len,
                                                      input bus_ctrl_pkg::slave_id_t id);
        logic [bus_ctrl_pkg::ADDR_WIDTH:0] sum;
        int depth;
        sum = {1'b0, first} + {1'b0, len};
        if (id == '0) begin
            return first;
        end
        depth = bus_ctrl_pkg::SLAVE_DEPTHS[id];
        if (int'(sum) >= depth) begin
            return bus_ctrl_pkg::addr_t'(depth - 1);
        end
        return sum[bus_ctrl_pkg::ADDR_WIDTH-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) begin
            done_all[i] = (setup[i].slave_id == '0) | done_seen[i] | done_com[i];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            bus_ctrl_pkg::master_slave_sel: if (step) begin
                next_state = (sw[3:0] == '0) ? bus_ctrl_pkg::communication_done
                                             : bus_ctrl_pkg::read_write_sel;
            end
            bus_ctrl_pkg::read_write_sel: if (step) next_state = bus_ctrl_pkg::external_write_sel;
            bus_ctrl_pkg::external_write_sel: if (step) begin
                case (sw[1:0])
                    2'b01:   next_state = bus_ctrl_pkg::external_write_m1;
                    2'b10:   next_state = bus_ctrl_pkg::external_write_m2;
                    2'b11:   next_state = bus_ctrl_pkg::external_write_m1_2;
                    default: next_state = bus_ctrl_pkg::start_addr_sel_m1;
                endcase
            end
            bus_ctrl_pkg::external_write_m1,
            bus_ctrl_pkg::external_write_m2: if (step) next_state = bus_ctrl_pkg::start_addr_sel_m1;
            bus_ctrl_pkg::external_write_m1_2: if (step) next_state = bus_ctrl_pkg::external_write_m2;
            bus_ctrl_pkg::start_addr_sel_m1: if (step) next_state = bus_ctrl_pkg::start_addr_sel_m2;
            bus_ctrl_pkg::start_addr_sel_m2: if (step) next_state = bus_ctrl_pkg::end_addr_sel_m1;
            bus_ctrl_pkg::end_addr_sel_m1: if (step) next_state = bus_ctrl_pkg::end_addr_sel_m2;
            bus_ctrl_pkg::end_addr_sel_m2: if (step) next_state = bus_ctrl_pkg::config_masters;
            bus_ctrl_pkg::config_masters: if (config_finished) begin
                next_state = bus_ctrl_pkg::communication_ready;
            end
            bus_ctrl_pkg::communication_ready: if (step) next_state = bus_ctrl_pkg::communicating;
            bus_ctrl_pkg::communicating: if (&done_all) next_state = bus_ctrl_pkg::communication_done;
            default: ;  // communication_done holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= bus_ctrl_pkg::master_slave_sel;
            setup     <= '{default: '0};
            eoc       <= '0;
            done_seen <= '0;
        end else begin
            state <= next_state;
            eoc   <= '0;
            case (state)
                bus_ctrl_pkg::master_slave_sel: if (step) begin
                    for (int i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) begin
                        setup[i].slave_id <= sw[i*bus_ctrl_pkg::SLAVE_ID_WIDTH +:
                                                bus_ctrl_pkg::SLAVE_ID_WIDTH];
                    end
                    // no slave anywhere, masters skip straight to their end
                    if (next_state == bus_ctrl_pkg::communication_done) eoc <= '1;
                end
                bus_ctrl_pkg::read_write_sel: if (step) begin
                    for (int i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) setup[i].rd_wr <= sw[i];
                end
                bus_ctrl_pkg::external_write_sel: if (step) begin
                    for (int i = 0; i < bus_ctrl_pkg::MASTER_COUNT; i++) setup[i].in_ex <= sw[i];
                end
                bus_ctrl_pkg::external_write_m1,
                bus_ctrl_pkg::external_write_m1_2: if (next_word) setup[0].burst <= 1'b1;
                bus_ctrl_pkg::external_write_m2: if (next_word) setup[1].burst <= 1'b1;
                bus_ctrl_pkg::start_addr_sel_m1: if (step) begin
                    setup[0].first_addr <= sw[bus_ctrl_pkg::ADDR_WIDTH-1:0];
                end
                bus_ctrl_pkg::start_addr_sel_m2: if (step) begin
                    setup[1].first_addr <= sw[bus_ctrl_pkg::ADDR_WIDTH-1:0];
                end
                bus_ctrl_pkg::end_addr_sel_m1: if (step) begin
                    setup[0].last_addr <= clamp_end(setup[0].first_addr,
                                                    sw[bus_ctrl_pkg::ADDR_WIDTH-1:0],
                                                    setup[0].slave_id);
                end
                bus_ctrl_pkg::end_addr_sel_m2: if (step) begin
                    setup[1].last_addr <= clamp_end(setup[1].first_addr,
                                                    sw[bus_ctrl_pkg::ADDR_WIDTH-1:0],
                                                    setup[1].slave_id);
                end
                bus_ctrl_pkg::communicating: done_seen <= done_seen | done_com;
                default: ;
            endcase
        end
    end

    // bit 0 idle, bit 1 ready, bit 2 done, bit 3 busy
    assign status = {state == bus_ctrl_pkg::communicating,
                     state == bus_ctrl_pkg::communication_done,
                     state == bus_ctrl_pkg::communication_ready,
                     state == bus_ctrl_pkg::master_slave_sel};

endmodule

//--- verilog/bus_ctrl_pkg.sv
package bus_ctrl_pkg;

    localparam int MASTER_COUNT   = 2;
    localparam int DATA_WIDTH     = 16;
    localparam int ADDR_WIDTH     = 12;  // deepest slave holds 4096 words
    localparam int SLAVE_ID_WIDTH = 2;   // id 0 is "no slave"

    localparam int SLAVE_DEPTHS [1:3] = '{4096, 4096, 2048};

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [SLAVE_ID_WIDTH-1:0] slave_id_t;

    typedef enum logic [3:0] {
        master_slave_sel,
        read_write_sel,
        external_write_sel,
        external_write_m1,
        external_write_m1_2,
        external_write_m2,
        start_addr_sel_m1,
        start_addr_sel_m2,
        end_addr_sel_m1,
        end_addr_sel_m2,
        config_masters,
        communication_ready,
        communicating,
        communication_done
    } main_state_t;

    typedef enum logic [1:0] {
        config_start,
        config_middle,
        config_last,
        config_done
    } config_state_t;

    typedef struct packed {
        logic      rd_wr;       // 1 is write
        logic      in_ex;       // master takes words written by hand
        logic      burst;
        slave_id_t slave_id;
        addr_t     first_addr;
        addr_t     last_addr;
    } master_setup_t;

    typedef struct packed {
        logic          start;
        logic          eoc;
        master_setup_t setup;
        addr_t         address;
        data_t         data;
    } master_cmd_t;

endpackage
